// ==== all.f ====
+incdir+common
common/cache_pkg.sv
dcache/dcache_array.sv
hdl/cache_sync.sv
icache/icache_array.sv
hdl/fence_sync_top.sv
verification/fence_sync_asserts.sv
verification/fence_sync_checker.sv
verification/fence_sync_tb.sv

// ==== verification/fence_sync_tb.sv ====
`default_nettype none

`include "cache_sync_config.svh"

module fence_sync_tb;

  localparam int FENCE_TIMEOUT = 200;
  localparam logic [1:0] K_STORE = 2'd0;
  localparam logic [1:0] K_FENCE = 2'd1;
  localparam logic [1:0] K_FETCH = 2'd2;

  // data is the store value, or the expected instruction for a fetch
  typedef struct packed {
    logic [1:0]  kind;
    logic [31:0] addr;
    logic [31:0] data;
    logic        exp_hit;
  } step_t;

  logic        clk = 1'b0;
  logic        rst;
  logic        i_st_en;
  logic [31:0] i_st_addr;
  logic [31:0] i_st_data;
  logic        i_fetch_en;
  logic [31:0] i_fetch_addr;
  logic        o_fetch_hit;
  logic [31:0] o_fetch_inst;
  logic        i_fencei_req;
  logic        o_fencei_ack;
  logic        exp_hit;
  logic [31:0] exp_inst;
  logic [31:0] chk_tests;
  logic [31:0] chk_errors;

  // reference model, last word stored per line
  logic [27:0] dc_tag [`CS_LINES];
  logic        dc_vld [`CS_LINES];
  logic [31:0] dc_word [`CS_LINES][4];
  logic [27:0] ic_tag [`CS_LINES];
  logic        ic_vld [`CS_LINES];
  logic [31:0] ic_word [`CS_LINES][4];

  step_t       steps[$];
  step_t       cur;
  logic [31:0] rnd_state;
  logic        acked;
  int          timeouts;

  always #5 clk = ~clk;

  fence_sync_top fence_sync_top_inst (
    .clk          (clk),
    .rst          (rst),
    .i_st_en      (i_st_en),
    .i_st_addr    (i_st_addr),
    .i_st_data    (i_st_data),
    .i_fetch_en   (i_fetch_en),
    .i_fetch_addr (i_fetch_addr),
    .o_fetch_hit  (o_fetch_hit),
    .o_fetch_inst (o_fetch_inst),
    .i_fencei_req (i_fencei_req),
    .o_fencei_ack (o_fencei_ack)
  );

  fence_sync_checker fence_sync_checker_inst (
    .clk          (clk),
    .rst          (rst),
    .i_fetch_en   (i_fetch_en),
    .i_fetch_addr (i_fetch_addr),
    .i_exp_hit    (exp_hit),
    .i_exp_inst   (exp_inst),
    .i_fetch_hit  (o_fetch_hit),
    .i_fetch_inst (o_fetch_inst),
    .i_fencei_req (i_fencei_req),
    .i_fencei_ack (o_fencei_ack),
    .o_tests      (chk_tests),
    .o_errors     (chk_errors)
  );

  bind cache_sync fence_sync_asserts fence_sync_asserts_inst (
    .clk          (clk),
    .rst          (rst),
    .i_fencei_ack (o_fencei_ack),
    .i_rpackack   (o_sync_dcache_rpackack),
    .i_wreq       (o_sync_icache_wreq),
    .i_wack       (i_sync_icache_wack)
  );

  // xorshift32 step
  function automatic logic [31:0] next_rand(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic add_store(input logic [31:0] addr);
    logic [3:0] idx;
    step_t      s;
    idx = addr[7:4];
    rnd_state = next_rand(rnd_state);
    // new tag, line starts over from zero
    if (!dc_vld[idx] || (dc_tag[idx] != addr[31:4])) begin
      for (int w = 0; w < 4; w++) begin
        dc_word[idx][w] = '0;
      end
    end
    dc_tag[idx] = addr[31:4];
    dc_vld[idx] = 1'b1;
    dc_word[idx][addr[3:2]] = rnd_state;
    s = '{kind: K_STORE, addr: addr, data: rnd_state, exp_hit: 1'b0};
    steps.push_back(s);
  endtask

  // every valid dcache line lands in the icache
  task automatic add_fence();
    step_t s;
    for (int n = 0; n < `CS_LINES; n++) begin
      if (dc_vld[n]) begin
        ic_vld[n] = 1'b1;
        ic_tag[n] = dc_tag[n];
        for (int w = 0; w < 4; w++) begin
          ic_word[n][w] = dc_word[n][w];
        end
      end
    end
    s = '{kind: K_FENCE, addr: '0, data: '0, exp_hit: 1'b0};
    steps.push_back(s);
  endtask

  task automatic add_fetch(input logic [31:0] addr);
    logic [3:0] idx;
    step_t      s;
    idx = addr[7:4];
    s.kind    = K_FETCH;
    s.addr    = addr;
    s.exp_hit = ic_vld[idx] && (ic_tag[idx] == addr[31:4]);
    s.data    = s.exp_hit ? ic_word[idx][addr[3:2]] : '0;
    steps.push_back(s);
  endtask

  task automatic build_table();
    for (int n = 0; n < `CS_LINES; n++) begin
      dc_vld[n] = 1'b0;
      ic_vld[n] = 1'b0;
    end
    add_store(32'h0000_1000);
    add_store(32'h0000_1008);
    // same word twice, later value wins
    add_store(32'h0000_2034);
    add_store(32'h0000_2034);
    // index 5 under two tags
    add_store(32'h0000_3050);
    add_store(32'h0000_4050);
    // last index, rack near the final fill
    add_store(32'h0000_50f0);
    // icache still empty
    add_fetch(32'h0000_1000);
    add_fetch(32'h0000_2034);
    add_fence();
    add_fetch(32'h0000_1000);
    add_fetch(32'h0000_1008);
    add_fetch(32'h0000_1004);
    add_fetch(32'h0000_100c);
    add_fetch(32'h0000_2034);
    add_fetch(32'h0000_4050);
    add_fetch(32'h0000_3050);
    add_fetch(32'h0000_50f0);
    // stores after the first fence, hidden until the second
    add_store(32'h0000_6080);
    add_store(32'h0000_1004);
    add_fetch(32'h0000_6080);
    add_fetch(32'h0000_1004);
    add_fence();
    add_fetch(32'h0000_6080);
    add_fetch(32'h0000_1004);
    add_fetch(32'h0000_1000);
  endtask

  initial begin
    rst          = 1'b1;
    i_st_en      = 1'b0;
    i_st_addr    = '0;
    i_st_data    = '0;
    i_fetch_en   = 1'b0;
    i_fetch_addr = '0;
    i_fencei_req = 1'b0;
    exp_hit      = 1'b0;
    exp_inst     = '0;
    timeouts     = 0;
    rnd_state    = 32'h1451a5bd;
    build_table();
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    foreach (steps[i]) begin
      cur = steps[i];
      @(posedge clk);
      case (cur.kind)
        K_STORE: begin
          i_st_en   <= 1'b1;
          i_st_addr <= cur.addr;
          i_st_data <= cur.data;
        end
        K_FENCE: begin
          i_fencei_req <= 1'b1;
        end
        default: begin
          i_fetch_en   <= 1'b1;
          i_fetch_addr <= cur.addr;
          exp_hit      <= cur.exp_hit;
          exp_inst     <= cur.data;
        end
      endcase
      @(posedge clk);
      i_st_en      <= 1'b0;
      i_fencei_req <= 1'b0;
      i_fetch_en   <= 1'b0;
      if (cur.kind == K_FENCE) begin
        acked = 1'b0;
        for (int c = 0; (c < FENCE_TIMEOUT) && !acked; c++) begin
          @(negedge clk);
          acked = o_fencei_ack;
        end
        if (!acked) begin
          $display("Timeout: no fence.i acknowledge within %0d cycles at step %0d",
                   FENCE_TIMEOUT, i);
          timeouts++;
          break;
        end
      end
    end
    // last fetch result lands one cycle later
    repeat (3) @(negedge clk);
    $display("tests %0d, errors %0d, timeouts %0d", chk_tests, chk_errors, timeouts);
    if ((chk_errors == 0) && (timeouts == 0)) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verification/fence_sync_checker.sv ====
`default_nettype none

module fence_sync_checker (
  input  wire         clk,
  input  wire         rst,
  // fetch request with the expected result
  input  wire         i_fetch_en,
  input  wire  [31:0] i_fetch_addr,
  input  wire         i_exp_hit,
  input  wire  [31:0] i_exp_inst,
  // registered fetch result from the DUT
  input  wire         i_fetch_hit,
  input  wire  [31:0] i_fetch_inst,
  // fence.i pair
  input  wire         i_fencei_req,
  input  wire         i_fencei_ack,
  output logic [31:0] o_tests,
  output logic [31:0] o_errors
);

  // fetch seen last cycle, result due now
  logic        pend;
  logic [31:0] pend_addr;
  logic        pend_hit;
  logic [31:0] pend_inst;
  // fence issued, ack not seen yet
  logic        fence_open;

  // mid-cycle sampling, registered outputs are settled by then
  always @(negedge clk) begin
    if (rst) begin
      pend       = 1'b0;
      fence_open = 1'b0;
      o_tests    = '0;
      o_errors   = '0;
    end else begin
      if (pend) begin
        o_tests = o_tests + 1;
        if (i_fetch_hit !== pend_hit) begin
          o_errors = o_errors + 1;
          $display("Mismatch at %0t: fetch %08h hit %0b, expected %0b",
                   $time, pend_addr, i_fetch_hit, pend_hit);
        end else if (pend_hit && (i_fetch_inst !== pend_inst)) begin
          o_errors = o_errors + 1;
          $display("Mismatch at %0t: fetch %08h returned %08h, expected %08h",
                   $time, pend_addr, i_fetch_inst, pend_inst);
        end else begin
          $display("test %0d: fetch %08h ok, hit %0b", o_tests, pend_addr, pend_hit);
        end
      end
      // capture this cycle's fetch for the next compare
      pend      = i_fetch_en;
      pend_addr = i_fetch_addr;
      pend_hit  = i_exp_hit;
      pend_inst = i_exp_inst;
      // each fence.i gets exactly one ack
      if (i_fencei_ack) begin
        o_tests = o_tests + 1;
        if (fence_open) begin
          fence_open = 1'b0;
          $display("test %0d: fence.i acknowledged at %0t", o_tests, $time);
        end else begin
          o_errors = o_errors + 1;
          $display("fence.i acknowledge seen at %0t with no fence.i pending", $time);
        end
      end
      if (i_fencei_req) begin
        fence_open = 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== verification/fence_sync_asserts.sv ====
`default_nettype none

module fence_sync_asserts (
  input wire clk,
  input wire rst,
  input wire i_fencei_ack,
  input wire i_rpackack,
  input wire i_wreq,
  input wire i_wack
);

  // packet ack only in the read stage, fill request only in the write stage
  pack_fill_apart: assert property (@(posedge clk) disable iff (rst)
    !(i_rpackack && i_wreq))
    else $error("rpackack and wreq are high in the same cycle");

  // fence.i done is a single-cycle pulse
  ack_one_cycle: assert property (@(posedge clk) disable iff (rst)
    i_fencei_ack |=> !i_fencei_ack)
    else $error("o_fencei_ack stays high for more than one cycle");

  // fill request holds until the icache takes it
  wreq_held: assert property (@(posedge clk) disable iff (rst)
    (i_wreq && !i_wack) |=> i_wreq)
    else $error("wreq dropped before wack");

endmodule

`default_nettype wire

// ==== hdl/fence_sync_top.sv ====
`default_nettype none

module fence_sync_top (
  input  wire          clk,
  input  wire          rst,
  // stores into the data cache
  input  wire          i_st_en,
  input  wire  [31:0]  i_st_addr,
  input  wire  [31:0]  i_st_data,
  // instruction fetch
  input  wire          i_fetch_en,
  input  wire  [31:0]  i_fetch_addr,
  output logic         o_fetch_hit,
  output logic [31:0]  o_fetch_inst,
  // fence.i
  input  wire          i_fencei_req,
  output logic         o_fencei_ack
);

  import cache_pkg::*;

  // data cache to cache_sync
  logic  dc_rreq;
  logic  dc_rack;
  logic  dc_rpackreq;
  logic  dc_rpackack;
  etag_t dc_retag;
  line_t dc_rdata;

  // cache_sync to instruction cache
  logic  ic_wreq;
  logic  ic_wack;
  etag_t ic_wetag;
  line_t ic_wdata;

  dcache_array dcache_array_inst (
    .clk             (clk),
    .rst             (rst),
    .i_st_en         (i_st_en),
    .i_st_addr       (i_st_addr),
    .i_st_data       (i_st_data),
    .i_sync_rreq     (dc_rreq),
    .i_sync_rpackack (dc_rpackack),
    .o_sync_rack     (dc_rack),
    .o_sync_rpackreq (dc_rpackreq),
    .o_sync_retag    (dc_retag),
    .o_sync_rdata    (dc_rdata)
  );

  cache_sync cache_sync_inst (
    .clk                    (clk),
    .rst                    (rst),
    .i_fencei_req           (i_fencei_req),
    .o_fencei_ack           (o_fencei_ack),
    .o_sync_dcache_rreq     (dc_rreq),
    .i_sync_dcache_rack     (dc_rack),
    .i_sync_dcache_rpackreq (dc_rpackreq),
    .o_sync_dcache_rpackack (dc_rpackack),
    .i_sync_dcache_retag    (dc_retag),
    .i_sync_dcache_rdata    (dc_rdata),
    .o_sync_icache_wreq     (ic_wreq),
    .i_sync_icache_wack     (ic_wack),
    .o_sync_icache_wetag    (ic_wetag),
    .o_sync_icache_wdata    (ic_wdata)
  );

  icache_array icache_array_inst (
    .clk          (clk),
    .rst          (rst),
    .i_fill_req   (ic_wreq),
    .o_fill_ack   (ic_wack),
    .i_fill_etag  (ic_wetag),
    .i_fill_data  (ic_wdata),
    .i_fetch_en   (i_fetch_en),
    .i_fetch_addr (i_fetch_addr),
    .o_fetch_hit  (o_fetch_hit),
    .o_fetch_inst (o_fetch_inst)
  );

endmodule

`default_nettype wire

// ==== icache/icache_array.sv ====
`default_nettype none

`include "cache_sync_config.svh"

module icache_array (
  input  wire                   clk,
  input  wire                   rst,
  // line fill from cache_sync
  input  wire                   i_fill_req,
  output logic                  o_fill_ack,
  input  wire cache_pkg::etag_t i_fill_etag,
  input  wire cache_pkg::line_t i_fill_data,
  // fetch port, result one cycle later
  input  wire                   i_fetch_en,
  input  wire  [31:0]           i_fetch_addr,
  output logic                  o_fetch_hit,
  output logic [31:0]           o_fetch_inst
);

  import cache_pkg::*;

  line_t                line_mem [`CS_LINES];
  etag_t                line_tag [`CS_LINES];
  logic [`CS_LINES-1:0] line_vld;

  logic [`CS_IDX_W-1:0] fill_idx;
  logic                 fill_go;
  etag_t                fetch_etag;
  logic [`CS_IDX_W-1:0] fetch_idx;
  logic [1:0]           fetch_word;
  logic                 fetch_match;

  // index straight from the low tag bits
  assign fill_idx    = i_fill_etag[`CS_IDX_W-1:0];
  // first cycle of a request, ack and write follow
  assign fill_go     = i_fill_req & ~o_fill_ack;

  assign fetch_etag  = i_fetch_addr[31:32-`CS_TAG_W];
  assign fetch_idx   = fetch_etag[`CS_IDX_W-1:0];
  assign fetch_word  = i_fetch_addr[3:2];
  assign fetch_match = line_vld[fetch_idx] & (line_tag[fetch_idx] == fetch_etag);

  always_ff @(posedge clk) begin
    if (rst) begin
      line_vld    <= '0;
      o_fill_ack  <= 1'b0;
      o_fetch_hit <= 1'b0;
    end else begin
      // single-cycle ack
      o_fill_ack <= fill_go;
      if (fill_go) begin
        line_vld[fill_idx] <= 1'b1;
      end
      // no fetch means no hit
      o_fetch_hit <= i_fetch_en & fetch_match;
    end
  end

  // whole-line fill, word select for fetch
  always_ff @(posedge clk) begin
    if (fill_go) begin
      line_mem[fill_idx] <= i_fill_data;
      line_tag[fill_idx] <= i_fill_etag;
    end
    if (i_fetch_en) begin
      o_fetch_inst <= line_mem[fetch_idx].word[fetch_word];
    end
  end

endmodule

`default_nettype wire

// ==== hdl/cache_sync.sv ====
`default_nettype none

module cache_sync (
  input  wire                   clk,
  input  wire                   rst,
  // fence.i request and done pulse
  input  wire                   i_fencei_req,
  output logic                  o_fencei_ack,
  // data cache walk
  output logic                  o_sync_dcache_rreq,
  input  wire                   i_sync_dcache_rack,
  input  wire                   i_sync_dcache_rpackreq,
  output logic                  o_sync_dcache_rpackack,
  input  wire cache_pkg::etag_t i_sync_dcache_retag,
  input  wire cache_pkg::line_t i_sync_dcache_rdata,
  // instruction cache fill
  output logic                  o_sync_icache_wreq,
  input  wire                   i_sync_icache_wack,
  output cache_pkg::etag_t      o_sync_icache_wetag,
  output cache_pkg::line_t      o_sync_icache_wdata
);

  import cache_pkg::*;

  // idle, read a packet from the data cache, write it to the instruction cache
  localparam logic [1:0] ST_IDLE  = 2'd0;
  localparam logic [1:0] ST_READ  = 2'd1;
  localparam logic [1:0] ST_WRITE = 2'd2;

  logic [1:0] state;
  // walk finished while the last line was still being written
  logic       done_pend;
  logic       hs_rd;
  logic       hs_wr;
  logic       take_pack;

  assign hs_rd     = o_sync_dcache_rreq & i_sync_dcache_rack;
  assign hs_wr     = o_sync_icache_wreq & i_sync_icache_wack;
  // accept a packet only in the read stage
  assign take_pack = (state == ST_READ) & ~hs_rd & i_sync_dcache_rpackreq;

  always_ff @(posedge clk) begin
    if (rst) begin
      state                  <= ST_IDLE;
      done_pend              <= 1'b0;
      o_fencei_ack           <= 1'b0;
      o_sync_dcache_rreq     <= 1'b0;
      o_sync_dcache_rpackack <= 1'b0;
      o_sync_icache_wreq     <= 1'b0;
    end else begin
      // both acks are single-cycle pulses
      o_fencei_ack           <= 1'b0;
      o_sync_dcache_rpackack <= 1'b0;
      // rreq spans the whole sync and ends at the rack handshake
      if (hs_rd) begin
        o_sync_dcache_rreq <= 1'b0;
      end
      case (state)
        ST_IDLE: begin
          // fence requests inside a sync never reach here
          if (i_fencei_req) begin
            state              <= ST_READ;
            o_sync_dcache_rreq <= 1'b1;
          end
        end
        ST_READ: begin
          if (hs_rd) begin
            state        <= ST_IDLE;
            o_fencei_ack <= 1'b1;
          end else if (take_pack) begin
            o_sync_dcache_rpackack <= 1'b1;
            state                  <= ST_WRITE;
          end
        end
        ST_WRITE: begin
          // rack can land here when the last valid line is near index 15
          // the fence ack then waits for that line's fill
          if (hs_rd) begin
            done_pend <= 1'b1;
          end
          if (hs_wr) begin
            o_sync_icache_wreq <= 1'b0;
            if (done_pend | hs_rd) begin
              state        <= ST_IDLE;
              done_pend    <= 1'b0;
              o_fencei_ack <= 1'b1;
            end else begin
              state <= ST_READ;
            end
          end else begin
            // raised the cycle after rpackack, so never together with it
            o_sync_icache_wreq <= 1'b1;
          end
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  // captured line stays put until the fill is acked
  always_ff @(posedge clk) begin
    if (take_pack) begin
      o_sync_icache_wetag <= i_sync_dcache_retag;
      o_sync_icache_wdata <= i_sync_dcache_rdata;
    end
  end

endmodule

`default_nettype wire

// ==== dcache/dcache_array.sv ====
`default_nettype none

`include "cache_sync_config.svh"

module dcache_array (
  input  wire                   clk,
  input  wire                   rst,
  // store port, one word per cycle
  input  wire                   i_st_en,
  input  wire  [31:0]           i_st_addr,
  input  wire  [31:0]           i_st_data,
  // sync walk toward cache_sync
  input  wire                   i_sync_rreq,
  input  wire                   i_sync_rpackack,
  output logic                  o_sync_rack,
  output logic                  o_sync_rpackreq,
  output cache_pkg::etag_t      o_sync_retag,
  output cache_pkg::line_t      o_sync_rdata
);

  import cache_pkg::*;

  localparam int unsigned LAST_IDX = `CS_LINES - 1;

  // line storage, tag and valid per index
  line_t                line_mem [`CS_LINES];
  etag_t                line_tag [`CS_LINES];
  logic [`CS_LINES-1:0] line_vld;

  // store decode
  etag_t                st_etag;
  logic [`CS_IDX_W-1:0] st_idx;
  logic [1:0]           st_word;
  logic                 st_hit;
  line_t                st_line;

  // walker
  logic [`CS_IDX_W-1:0] walk_idx;
  logic                 walk_on;
  logic                 walk_offer;
  logic                 walk_step;
  logic                 walk_last;

  assign st_etag = i_st_addr[31:32-`CS_TAG_W];
  assign st_idx  = st_etag[`CS_IDX_W-1:0];
  assign st_word = i_st_addr[3:2];
  // same line already resident
  assign st_hit  = line_vld[st_idx] & (line_tag[st_idx] == st_etag);

  // merged line for the store
  // a new tag starts from an all-zero line
  always_comb begin
    st_line = line_mem[st_idx];
    if (!st_hit) begin
      st_line.raw = '0;
    end
    st_line.word[st_word] = i_st_data;
  end

  // walk only while rreq is up, and stop in the rack cycle
  assign walk_on    = i_sync_rreq & ~o_sync_rack;
  // valid line, no packet out yet
  assign walk_offer = walk_on & ~o_sync_rpackreq & line_vld[walk_idx];
  // move on after the packet ack, or straight past an invalid line
  assign walk_step  = walk_on & (o_sync_rpackreq ? i_sync_rpackack : ~line_vld[walk_idx]);
  assign walk_last  = (walk_idx == LAST_IDX[`CS_IDX_W-1:0]);

  always_ff @(posedge clk) begin
    if (rst) begin
      line_vld        <= '0;
      walk_idx        <= '0;
      o_sync_rack     <= 1'b0;
      o_sync_rpackreq <= 1'b0;
    end else begin
      if (i_st_en) begin
        line_vld[st_idx] <= 1'b1;
      end
      // one-cycle rack once index 15 is done
      o_sync_rack <= walk_step & walk_last;
      // packet request held until acked
      if (walk_offer) begin
        o_sync_rpackreq <= 1'b1;
      end else if (walk_step) begin
        o_sync_rpackreq <= 1'b0;
      end
      // wrap to 0 so the next fence starts clean
      if (walk_step) begin
        walk_idx <= walk_last ? '0 : walk_idx + 1'b1;
      end
    end
  end

  // payload, plus a packet copy kept stable while rpackreq is up
  always_ff @(posedge clk) begin
    if (i_st_en) begin
      line_mem[st_idx] <= st_line;
      line_tag[st_idx] <= st_etag;
    end
    if (walk_offer) begin
      o_sync_retag <= line_tag[walk_idx];
      o_sync_rdata <= line_mem[walk_idx];
    end
  end

endmodule

`default_nettype wire

// ==== common/cache_pkg.sv ====
`default_nettype none

`include "cache_sync_config.svh"

package cache_pkg;

  // extended tag, address bits 31 down to 4
  // low CS_IDX_W bits double as the cache index
  typedef logic [`CS_TAG_W-1:0] etag_t;

  // one cache line, read in two ways
  // raw view is the whole line as the sync walk moves it
  // word view is the fetch side, word k sits at address bits 3..2 == k
  // word 0 is the low 32 bits, little-endian like the core
  typedef union packed {
    logic [`CS_LINE_W-1:0]            raw;
    logic [`CS_LINE_W/32-1:0][31:0]   word;
  } line_t;

endpackage

`default_nettype wire

// ==== common/cache_sync_config.svh ====
`ifndef CACHE_SYNC_CONFIG_SVH
`define CACHE_SYNC_CONFIG_SVH

// extended tag width
// address bits 31 down to 4, so one tag value names one 16-byte line
`define CS_TAG_W 28

// line payload in bits
// four 32-bit instruction words per line
`define CS_LINE_W 128

// lines per cache
// both caches are direct-mapped with the same depth
`define CS_LINES 16

// index width
// low bits of the extended tag, which are address bits 7 down to 4
// must match log2 of the line count
`define CS_IDX_W 4

`endif
